// ==== bench/mandel_tb.sv ====
`timescale 1ns/10ps

module mandel_tb
	import video_pkg::*, mandel_pkg::*;
();

	localparam int NUM_VIEWS   = 6;
	localparam int RANDOM_SEED = 32'hb497b6f3;
	// Two passes of worst-case tiles plus three frames per view, then doubled
	localparam int WATCHDOG_CYCLES = 2 * NUM_VIEWS * (2 * BANK_DEPTH * 52 + 3 * FRAME_CYCLES);

	logic       clk;
	logic       reset;
	view_t      view;
	iter_t      max_iter;
	video_out_t video;
	logic       render_done;

	int mismatches = 0;
	int failures   = 0;

	mandel_top i_mandel_top (
		.clk         (clk),
		.reset       (reset),
		.view        (view),
		.max_iter    (max_iter),
		.video       (video),
		.render_done (render_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rgb(input string what, input rgb_t got, input rgb_t want);
		if (got !== want) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", what, got, want);
		end
	endtask

	task automatic check_pos(input string what, input pixel_pos_t got, input pixel_pos_t want);
		if (got !== want) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", what, got, want);
		end
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("error: %s", msg);
	endtask

	function automatic pixel_pos_t make_pos(input int x, input int y);
		pixel_pos_t p;
		p.x = pos_t'(x);
		p.y = pos_t'(y);
		return p;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Two's complement wrap to the 4.23 width
	function automatic longint wrap_coord(input longint v);
		return (v <<< (64 - COORD_W)) >>> (64 - COORD_W);
	endfunction

	// Escape count for one screen pixel, 0 for points that hit the limit
	function automatic logic [7:0] model_color(input view_t v, input iter_t lim,
			input int x, input int y);
		longint step;
		longint c_re;
		longint c_im;
		longint zr;
		longint zi;
		longint rr;
		longint ii;
		longint nr;
		int     n;
		step = longint'(1) <<< (FRAC_BITS - STEP_SHIFT - int'(v.scale));
		c_re = wrap_coord(longint'($signed(v.center_re)) + longint'(x - SCREEN_W / 2) * step);
		c_im = wrap_coord(longint'($signed(v.center_im)) + longint'(y - SCREEN_H / 2) * step);
		zr = 0;
		zi = 0;
		for (n = 0; n < int'(lim); n++) begin
			// Floored squares, bound of 4.0
			rr = (zr * zr) >>> FRAC_BITS;
			ii = (zi * zi) >>> FRAC_BITS;
			if (rr + ii > (longint'(4) <<< FRAC_BITS)) begin
				return n[7:0];
			end
			nr = wrap_coord(rr - ii + c_re);
			zi = wrap_coord(((zr * zi) >>> (FRAC_BITS - 1)) + c_im);
			zr = nr;
		end
		return 8'd0;
	endfunction

	// 3-3-2 into 8-8-8, low bits zero
	function automatic rgb_t expand_color(input logic [7:0] c);
		rgb_t r;
		r.red   = {c[7:5], 5'd0};
		r.green = {c[4:2], 5'd0};
		r.blue  = {c[1:0], 6'd0};
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and capture
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_passes(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (render_done) begin
				seen++;
			end
		end
	endtask

	// One frame between vsync pulses, pixel by pixel against the model
	task automatic capture_frame(input view_t v, input iter_t lim);
		int   x;
		int   y;
		logic de_q;
		@(negedge clk);
		while (video.vsync) @(negedge clk);
		while (!video.vsync) @(negedge clk);
		x = 0;
		y = 0;
		de_q = 1'b0;
		while (video.vsync) begin
			if (video.de) begin
				if (x < SCREEN_W && y < SCREEN_H) begin
					check_rgb($sformatf("video.rgb at (%0d,%0d)", x, y), video.rgb,
						expand_color(model_color(v, lim, x, y)));
				end
				x++;
			end else if (de_q) begin
				// Falling de closes a line
				check_pos("line length", make_pos(x, y), make_pos(SCREEN_W, y));
				x = 0;
				y++;
			end
			de_q = video.de;
			@(negedge clk);
		end
		check_pos("frame lines", make_pos(0, y), make_pos(0, SCREEN_H));
	endtask

	initial begin
		view_t next_view;
		iter_t next_lim;
		void'($urandom(RANDOM_SEED));
		reset    = 1'b1;
		view     = '0;
		max_iter = iter_t'(16);
		next_view = '0;
		next_lim  = iter_t'(16);

		// Outputs at their reset values from the first edge on
		@(posedge clk);
		repeat (3) begin
			@(negedge clk);
			if (!video.hsync || !video.vsync) begin
				report_failure("sync low during reset");
			end
			if (render_done || video.de) begin
				report_failure("render_done or de high during reset");
			end
			check_rgb("video.rgb in reset", video.rgb, '0);
			@(posedge clk);
		end
		reset <= 1'b0;

		// Quiet until the first active line
		@(negedge clk);
		while (!video.de) begin
			if (render_done) begin
				report_failure("render_done high before first active line");
			end
			check_rgb("video.rgb before first line", video.rgb, '0);
			@(negedge clk);
		end

		for (int i = 0; i < NUM_VIEWS; i++) begin
			// Odd steps change only the limit
			if (i % 2 == 0) begin
				next_view.center_re = coord_t'(int'($urandom_range(32'h0100_0000, 0)) - 32'sh0080_0000);
				next_view.center_im = coord_t'(int'($urandom_range(32'h0100_0000, 0)) - 32'sh0080_0000);
				next_view.scale     = scale_t'($urandom_range(3, 0));
			end
			next_lim = iter_t'($urandom_range(48, 8));
			if (i % 2 == 1 && next_lim == max_iter) begin
				next_lim = (next_lim == iter_t'(48)) ? iter_t'(8) : next_lim + iter_t'(1);
			end
			@(posedge clk);
			view     <= next_view;
			max_iter <= next_lim;
			wait_passes(2);
			capture_frame(next_view, next_lim);
		end

		$display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== bench/mandel_tb_assert.sv ====
`timescale 1ns/10ps

module mandel_tb_assert
	import video_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input video_out_t video,
	input logic       render_done
);

	// Blanking carries no color
	a_rgb_blank: assert property (@(posedge clk) disable iff (reset)
		!video.de |-> video.rgb == '0)
		else $error("rgb not zero while de is low");

	// Active video never overlaps a sync pulse
	a_de_sync: assert property (@(posedge clk) disable iff (reset)
		video.de |-> (video.hsync && video.vsync))
		else $error("de high during a sync pulse");

	// Pass end is a single-cycle strobe
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		render_done |=> !render_done)
		else $error("render_done high for two cycles");

	// Low for exactly H_PULSE clocks
	a_hsync_len: assert property (@(posedge clk) disable iff (reset)
		$fell(video.hsync) |-> ##H_PULSE $rose(video.hsync))
		else $error("hsync pulse length wrong");

endmodule

bind mandel_top mandel_tb_assert i_mandel_tb_assert (
	.clk         (clk),
	.reset       (reset),
	.video       (video),
	.render_done (render_done)
);

// ==== common/mandel_pkg.sv ====
package mandel_pkg;
	import video_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Fixed point
	////////////////////////////////////////////////////////////////////////////

	// 4.23 signed, range of about +-8
	localparam int FRAC_BITS = 23;
	localparam int COORD_W   = FRAC_BITS + 4;
	typedef logic signed [COORD_W-1:0] coord_t;

	// Full product of two coordinates, before rescale
	typedef logic signed [2*COORD_W-1:0] prod_t;

	// |z|^2 limit of 4.0 at product scale after the shift
	localparam prod_t ESCAPE_BOUND = prod_t'(4) << FRAC_BITS;

	typedef logic [12:0] iter_t;

	// Pixel step is 2^-(STEP_SHIFT + scale)
	typedef logic [2:0] scale_t;
	localparam int STEP_SHIFT = 3;

	////////////////////////////////////////////////////////////////////////////
	// Tiling and frame buffer
	////////////////////////////////////////////////////////////////////////////

	localparam int TILE_X      = 2;
	localparam int TILE_Y      = 2;
	localparam int NUM_SOLVERS = TILE_X * TILE_Y;
	localparam int TILES_X     = SCREEN_W / TILE_X;
	localparam int TILES_Y     = SCREEN_H / TILE_Y;
	localparam int BANK_DEPTH  = TILES_X * TILES_Y;

	typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
	} tile_pos_t;

	typedef struct packed {
		coord_t center_re;
		coord_t center_im;
		scale_t scale;
	} view_t;

	// One write fills the same address in every bank
	typedef struct packed {
		logic                      valid;
		bank_addr_t                addr;
		color_t [NUM_SOLVERS-1:0]  color;
	} fb_write_t;

	typedef enum logic [1:0] {S_FRAME, S_LOAD, S_SOLVE, S_WRITE} sched_state_t;

endpackage

// ==== common/video_pkg.sv ====
package video_pkg;

	// Visible area in pixels
	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 24;

	// Horizontal blanking, in clocks
	localparam int H_FRONT = 2;
	localparam int H_PULSE = 4;
	localparam int H_BACK  = 2;
	localparam int H_TOTAL = SCREEN_W + H_FRONT + H_PULSE + H_BACK;

	// Vertical blanking, in whole lines
	localparam int V_FRONT = 1;
	localparam int V_PULSE = 1;
	localparam int V_BACK  = 1;
	localparam int V_TOTAL = SCREEN_H + V_FRONT + V_PULSE + V_BACK;

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

	// Screen coordinate, wide enough for x up to 31
	typedef logic [5:0] pos_t;

	typedef struct packed {
		pos_t x;
		pos_t y;
	} pixel_pos_t;

	// 3-3-2 palette entry as stored in the frame buffer
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} color_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Both syncs low-active, de marks visible pixels
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
		rgb_t rgb;
	} video_out_t;

	typedef enum logic [1:0] {HS_ACTIVE, HS_FRONT, HS_PULSE, HS_BACK} h_state_t;
	typedef enum logic [1:0] {VS_ACTIVE, VS_FRONT, VS_PULSE, VS_BACK} v_state_t;

endpackage

// ==== filelist.f ====
common/video_pkg.sv
common/mandel_pkg.sv
render/tile_scheduler.sv
render/escape_solver.sv
render/render_engine.sv
src/frame_buffer.sv
src/scan_out.sv
src/mandel_top.sv
bench/mandel_tb_assert.sv
bench/mandel_tb.sv

// ==== render/escape_solver.sv ====
`timescale 1ns/10ps

module escape_solver
	import video_pkg::*, mandel_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  coord_t c_re,
	input  coord_t c_im,
	input  iter_t  max_iter,
	output logic   done,
	output color_t color
);

	coord_t zr;
	coord_t zi;
	coord_t zr_next;
	coord_t zi_next;
	iter_t  count;
	logic   busy;
	prod_t  p_rr;
	prod_t  p_ii;
	prod_t  p_ri;
	prod_t  sq_re;
	prod_t  sq_im;
	logic   escaped;
	logic   limit_hit;

	// Full-width products
	assign p_rr = zr * zr;
	assign p_ii = zi * zi;
	assign p_ri = zr * zi;

	// Back to 4.23, floor by arithmetic shift
	assign sq_re = p_rr >>> FRAC_BITS;
	assign sq_im = p_ii >>> FRAC_BITS;

	assign escaped   = (sq_re + sq_im) > ESCAPE_BOUND;
	assign limit_hit = count == max_iter;

	// Stays high once idle, so the scheduler AND holds
	assign done = !busy || escaped || limit_hit;

	// z^2 + c, the doubling folded into the shift
	assign zr_next = coord_t'(sq_re - sq_im) + c_re;
	assign zi_next = coord_t'(p_ri >>> (FRAC_BITS - 1)) + c_im;

	// Interior points black, else low byte of the count
	assign color = limit_hit ? '0 : color_t'(count[7:0]);

	// Iteration control
	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= '0;
		end else if (busy) begin
			if (escaped || limit_hit) begin
				busy <= 1'b0;
			end else begin
				count <= count + iter_t'(1);
			end
		end
	end

	// z datapath, frozen while done
	always_ff @(posedge clk) begin
		if (start) begin
			zr <= '0;
			zi <= '0;
		end else if (!done) begin
			zr <= zr_next;
			zi <= zi_next;
		end
	end

endmodule

// ==== render/render_engine.sv ====
`timescale 1ns/10ps

module render_engine
	import video_pkg::*, mandel_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  view_t     view,
	input  iter_t     max_iter,
	output fb_write_t fb_write,
	output logic      render_done
);

	logic                     load;
	logic                     write;
	logic                     all_done;
	tile_pos_t                tile;
	view_t                    view_q;
	iter_t                    max_iter_q;
	logic [NUM_SOLVERS-1:0]   done;
	color_t [NUM_SOLVERS-1:0] color;

	// Signed distance from screen center, scaled to the pixel step
	function automatic coord_t pixel_offset(input pos_t p, input pos_t mid, input scale_t scale);
		coord_t diff;
		diff = coord_t'(p) - coord_t'(mid);
		return diff <<< (FRAC_BITS - STEP_SHIFT - int'(scale));
	endfunction

	tile_scheduler i_tile_scheduler (
		.clk         (clk),
		.reset       (reset),
		.view        (view),
		.max_iter    (max_iter),
		.all_done    (all_done),
		.load        (load),
		.write       (write),
		.tile        (tile),
		.view_q      (view_q),
		.max_iter_q  (max_iter_q),
		.render_done (render_done)
	);

	// Solver b takes tile pixel x = b mod 2, y = b div 2
	for (genvar b = 0; b < NUM_SOLVERS; b++) begin : g_solver
		pos_t   px;
		pos_t   py;
		coord_t c_re;
		coord_t c_im;

		assign px = pos_t'(tile.x * TILE_X + b % TILE_X);
		assign py = pos_t'(tile.y * TILE_Y + b / TILE_X);

		always_ff @(posedge clk) begin
			if (load) begin
				c_re <= view_q.center_re + pixel_offset(px, pos_t'(SCREEN_W / 2), view_q.scale);
				c_im <= view_q.center_im + pixel_offset(py, pos_t'(SCREEN_H / 2), view_q.scale);
			end
		end

		escape_solver i_escape_solver (
			.clk      (clk),
			.reset    (reset),
			.start    (load),
			.c_re     (c_re),
			.c_im     (c_im),
			.max_iter (max_iter_q),
			.done     (done[b]),
			.color    (color[b])
		);
	end

	assign all_done = &done;

	// Tile write, one cycle after the strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			fb_write.valid <= 1'b0;
		end else begin
			fb_write.valid <= write;
		end
		if (write) begin
			fb_write.addr  <= bank_addr_t'(tile.y * TILES_X + tile.x);
			fb_write.color <= color;
		end
	end

endmodule

// ==== render/tile_scheduler.sv ====
`timescale 1ns/10ps

module tile_scheduler
	import mandel_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  view_t     view,
	input  iter_t     max_iter,
	input  logic      all_done,
	output logic      load,
	output logic      write,
	output tile_pos_t tile,
	output view_t     view_q,
	output iter_t     max_iter_q,
	output logic      render_done
);

	sched_state_t state;
	logic         last_col;
	logic         last_row;

	// Raster order, x fastest
	assign last_col = tile.x == 4'(TILES_X - 1);
	assign last_row = tile.y == 4'(TILES_Y - 1);

	// Strobes straight from state
	assign load  = state == S_LOAD;
	assign write = state == S_WRITE;

	////////////////////////////////////////////////////////////////////////////
	// Pass FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= S_FRAME;
			tile        <= '0;
			render_done <= 1'b0;
		end else begin
			render_done <= 1'b0;
			case (state)
				S_FRAME: begin
					tile  <= '0;
					state <= S_LOAD;
				end
				S_LOAD: begin
					// Points get registered this cycle
					state <= S_SOLVE;
				end
				S_SOLVE: begin
					// Variable length, slowest solver decides
					if (all_done) begin
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (!last_col) begin
						tile.x <= tile.x + 4'd1;
						state  <= S_LOAD;
					end else if (!last_row) begin
						tile.x <= 4'd0;
						tile.y <= tile.y + 4'd1;
						state  <= S_LOAD;
					end else begin
						// Last tile issued, start over
						render_done <= 1'b1;
						state       <= S_FRAME;
					end
				end
				default: begin
					state <= S_FRAME;
				end
			endcase
		end
	end

	// View and limit held for a whole pass
	// so an input change never tears the image
	always_ff @(posedge clk) begin
		if (state == S_FRAME) begin
			view_q     <= view;
			max_iter_q <= max_iter;
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# The exit status follows the search for the pass line in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module mandel_tb -o mandel_sim || exit 1

./obj_dir/mandel_sim | tee /dev/stderr | grep -qx "TEST PASSED" && exit 0 || exit 1

// ==== src/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer
	import video_pkg::*, mandel_pkg::*;
(
	input  logic       clk,
	input  fb_write_t  wr,
	input  pixel_pos_t rd_pos,
	output color_t     rd_color
);

	// One bank per position inside a tile
	color_t bank [NUM_SOLVERS][BANK_DEPTH];
	color_t bank_q [NUM_SOLVERS];

	bank_addr_t                     rd_addr;
	logic [$clog2(NUM_SOLVERS)-1:0] rd_sel;
	logic [$clog2(NUM_SOLVERS)-1:0] sel_q;

	// Tile address, row stride of TILES_X
	assign rd_addr = bank_addr_t'((rd_pos.y >> 1) * TILES_X + (rd_pos.x >> 1));

	// Low coordinate bits pick the bank
	assign rd_sel = {rd_pos.y[0], rd_pos.x[0]};

	////////////////////////////////////////////////////////////////////////////
	// Banks
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int b = 0; b < NUM_SOLVERS; b++) begin
			if (wr.valid) begin
				bank[b][wr.addr] <= wr.color[b];
			end
			// All banks read in parallel
			bank_q[b] <= bank[b][rd_addr];
		end
		// Select follows the data by one cycle
		sel_q <= rd_sel;
	end

	assign rd_color = bank_q[sel_q];

endmodule

// ==== src/mandel_top.sv ====
`timescale 1ns/10ps

module mandel_top
	import video_pkg::*, mandel_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  view_t      view,
	input  iter_t      max_iter,
	output video_out_t video,
	output logic       render_done
);

	fb_write_t  fb_write;
	pixel_pos_t rd_pos;
	color_t     rd_color;

	// Producer, fills the banks one tile at a time
	render_engine i_render_engine (
		.clk         (clk),
		.reset       (reset),
		.view        (view),
		.max_iter    (max_iter),
		.fb_write    (fb_write),
		.render_done (render_done)
	);

	frame_buffer i_frame_buffer (
		.clk      (clk),
		.wr       (fb_write),
		.rd_pos   (rd_pos),
		.rd_color (rd_color)
	);

	// Consumer, free-running and never stalls
	scan_out i_scan_out (
		.clk      (clk),
		.reset    (reset),
		.rd_pos   (rd_pos),
		.rd_color (rd_color),
		.video    (video)
	);

endmodule

// ==== src/scan_out.sv ====
`timescale 1ns/10ps

module scan_out
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	output pixel_pos_t rd_pos,
	input  color_t     rd_color,
	output video_out_t video
);

	h_state_t   h_state;
	h_state_t   h_next;
	v_state_t   v_state;
	v_state_t   v_next;
	pos_t       h_cnt;
	pos_t       v_cnt;
	pos_t       h_end;
	pos_t       v_end;
	logic       h_last;
	logic       v_last;
	logic       line_end;
	logic       active;
	logic       de_d1;
	logic [1:0] sync_d1;
	rgb_t       rgb_exp;

	// Length of each horizontal phase, in clocks
	always_comb begin
		case (h_state)
			HS_ACTIVE: begin h_end = pos_t'(SCREEN_W - 1); h_next = HS_FRONT;  end
			HS_FRONT:  begin h_end = pos_t'(H_FRONT - 1);  h_next = HS_PULSE;  end
			HS_PULSE:  begin h_end = pos_t'(H_PULSE - 1);  h_next = HS_BACK;   end
			default:   begin h_end = pos_t'(H_BACK - 1);   h_next = HS_ACTIVE; end
		endcase
	end

	// Same for vertical, in lines
	always_comb begin
		case (v_state)
			VS_ACTIVE: begin v_end = pos_t'(SCREEN_H - 1); v_next = VS_FRONT;  end
			VS_FRONT:  begin v_end = pos_t'(V_FRONT - 1);  v_next = VS_PULSE;  end
			VS_PULSE:  begin v_end = pos_t'(V_PULSE - 1);  v_next = VS_BACK;   end
			default:   begin v_end = pos_t'(V_BACK - 1);   v_next = VS_ACTIVE; end
		endcase
	end

	assign h_last   = h_cnt == h_end;
	assign v_last   = v_cnt == v_end;
	assign line_end = (h_state == HS_BACK) && h_last;
	assign active   = (h_state == HS_ACTIVE) && (v_state == VS_ACTIVE);

	// Position only meaningful in active video
	assign rd_pos.x = active ? h_cnt : '0;
	assign rd_pos.y = active ? v_cnt : '0;

	////////////////////////////////////////////////////////////////////////////
	// Timing FSMs
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			h_state <= HS_ACTIVE;
			h_cnt   <= '0;
			v_state <= VS_ACTIVE;
			v_cnt   <= '0;
		end else begin
			h_cnt <= h_last ? '0 : h_cnt + pos_t'(1);
			if (h_last) begin
				h_state <= h_next;
			end
			// Vertical steps once per full line
			if (line_end) begin
				v_cnt <= v_last ? '0 : v_cnt + pos_t'(1);
				if (v_last) begin
					v_state <= v_next;
				end
			end
		end
	end

	// 3-3-2 to 8-8-8, zero fill in the low bits
	assign rgb_exp.red   = {rd_color.red, 5'd0};
	assign rgb_exp.green = {rd_color.green, 5'd0};
	assign rgb_exp.blue  = {rd_color.blue, 6'd0};

	// Two stages to match the buffer read latency
	always_ff @(posedge clk) begin
		if (reset) begin
			de_d1       <= 1'b0;
			sync_d1     <= 2'b11;
			video.hsync <= 1'b1;
			video.vsync <= 1'b1;
			video.de    <= 1'b0;
			video.rgb   <= '0;
		end else begin
			de_d1       <= active;
			sync_d1     <= {h_state != HS_PULSE, v_state != VS_PULSE};
			video.hsync <= sync_d1[1];
			video.vsync <= sync_d1[0];
			video.de    <= de_d1;
			video.rgb   <= de_d1 ? rgb_exp : '0;
		end
	end

endmodule
